//--- Makefile
TOP = timer_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)
	verilator --lint-only -f src.f --top-module timer_top

sim:
	verilator --binary --timing --assert -j 0 -f src.f --top-module $(TOP) --Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF "** PASS **" sim.log

clean:
	rm -rf obj_dir sim.log

//--- source/clock_prescaler.sv
`timescale 1ns/1ps

module clock_prescaler (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            run_i,     // high only while FSM runs
    input  logic [timer_pkg::DIV_SEL_W-1:0] div_sel_i, // log2 of divide ratio
    output logic                            tick_o     // one clock per period
);
    import timer_pkg::*;

    // widest terminal count is 2^(2^DIV_SEL_W - 1) - 1
    localparam int PRE_W = (1 << DIV_SEL_W) - 1;

    logic [PRE_W-1:0] pre_cnt_q; // clocks since last tick
    logic [PRE_W-1:0] limit;     // 2^div_sel - 1

    // all ones shifted down, div_sel of 0 gives limit 0
    assign limit = {PRE_W{1'b1}} >> (PRE_W - int'(div_sel_i));

    assign tick_o = run_i && (pre_cnt_q == limit);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pre_cnt_q <= '0;
        end else if (!run_i || tick_o) begin
            pre_cnt_q <= '0; // stopped, or period done
        end else begin
            pre_cnt_q <= pre_cnt_q + PRE_W'(1);
        end
    end

endmodule

//--- source/timer_bus_slave.sv
`timescale 1ns/1ps

module timer_bus_slave #(
    parameter int DATA_W = 32, // bus data width
    parameter int ADDR_W = 3,  // bus address width
    parameter int CNT_W  = 32  // counter width, not above DATA_W
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            stb_i,
    input  logic                            we_i,
    input  logic [ADDR_W-1:0]               addr_i,
    input  logic [DATA_W-1:0]               dat_i,
    input  logic [CNT_W-1:0]                count_i,     // live count for TLR reads
    input  logic [CNT_W-1:0]                cmp_i,       // compare value for TCMP reads
    input  logic                            match_i,     // tick matched compare
    input  logic                            expire_i,    // one-shot run ended
    output logic [DATA_W-1:0]               dat_o,
    output logic                            ack_o,
    output logic                            irq_o,
    output logic                            en_o,
    output logic                            one_shot_o,
    output logic                            rst_on_cmp_o,
    output logic [timer_pkg::DIV_SEL_W-1:0] div_sel_o,
    output logic                            load_o,      // TLR write strobe
    output logic                            cmp_wr_o,    // TCMP write strobe
    output logic [CNT_W-1:0]                wr_data_o
);
    import timer_pkg::*;

    logic                    bus_go;    // first cycle of a strobe
    logic                    wr_go;
    logic                    rd_go;
    logic                    reg_hit;   // address is mapped
    timer_reg_e              reg_sel;
    logic [TCSR_W-1:0]       tcsr_q;    // {isr, div_sel, one_shot, rst_cmp, int_en, en}
    logic [TCSR_ISR_BIT-1:0] ctrl_next; // control bits below the flag
    logic                    isr_clr;   // write 1 to bit 7
    logic                    isr_next;
    logic [DATA_W-1:0]       rd_data;

    assign bus_go = stb_i && !ack_o; // same term that raises ack
    assign wr_go  = bus_go && we_i;
    assign rd_go  = bus_go && !we_i;

    always_comb begin // address decode, unmapped leaves reg_hit low
        reg_hit = 1'b1;
        reg_sel = TCSR_ADDR;
        case (addr_i)
            ADDR_W'(TCSR_ADDR): reg_sel = TCSR_ADDR;
            ADDR_W'(TLR_ADDR):  reg_sel = TLR_ADDR;
            ADDR_W'(TCMP_ADDR): reg_sel = TCMP_ADDR;
            default:            reg_hit = 1'b0;
        endcase
    end

    // counter side writes go out combinationally, land at the ack edge
    assign load_o    = wr_go && reg_hit && (reg_sel == TLR_ADDR);
    assign cmp_wr_o  = wr_go && reg_hit && (reg_sel == TCMP_ADDR);
    assign wr_data_o = dat_i[CNT_W-1:0];

    always_comb begin // next TCSR value
        ctrl_next = tcsr_q[TCSR_ISR_BIT-1:0];
        isr_clr   = 1'b0;
        if (wr_go && reg_hit && (reg_sel == TCSR_ADDR)) begin
            ctrl_next = dat_i[TCSR_ISR_BIT-1:0];
            isr_clr   = dat_i[TCSR_ISR_BIT];
        end
        if (expire_i) begin
            ctrl_next[TCSR_EN_BIT] = 1'b0; // one-shot drops enable
        end
        // new match sets, w1c clears, masked by the new int enable
        isr_next = ((tcsr_q[TCSR_ISR_BIT] && !isr_clr) || match_i)
                   && ctrl_next[TCSR_INT_EN_BIT];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack_o  <= 1'b0;
            tcsr_q <= '0;
        end else begin
            ack_o  <= stb_i && !ack_o; // one cycle, every other on held strobe
            tcsr_q <= {isr_next, ctrl_next};
        end
    end

    always_comb begin // read mux
        rd_data = '0;
        if (reg_hit) begin
            case (reg_sel)
                TCSR_ADDR: rd_data = DATA_W'(tcsr_q);
                TLR_ADDR:  rd_data = DATA_W'(count_i);
                TCMP_ADDR: rd_data = DATA_W'(cmp_i);
                default:   rd_data = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go) begin
            dat_o <= rd_data; // valid while ack_o is high
        end
    end

    assign en_o         = tcsr_q[TCSR_EN_BIT];
    assign one_shot_o   = tcsr_q[TCSR_ONE_SHOT_BIT];
    assign rst_on_cmp_o = tcsr_q[TCSR_RST_CMP_BIT];
    assign div_sel_o    = tcsr_q[TCSR_DIV_LSB +: DIV_SEL_W];
    assign irq_o        = tcsr_q[TCSR_ISR_BIT]; // sticky flag straight out

endmodule

//--- source/timer_counter.sv
`timescale 1ns/1ps

module timer_counter #(
    parameter int CNT_W = 32 // counter and compare width
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             tick_i,       // prescaled count enable
    input  logic             rst_on_cmp_i, // wrap to zero on match
    input  logic             load_i,       // TLR write
    input  logic             cmp_wr_i,     // TCMP write
    input  logic [CNT_W-1:0] wr_data_i,
    output logic [CNT_W-1:0] count_o,
    output logic [CNT_W-1:0] cmp_o,
    output logic             match_o       // same cycle as the tick
);

    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] cmp_q;
    logic             wrap;

    assign match_o = tick_i && (count_q == cmp_q); // compare only on ticks
    assign wrap    = match_o && rst_on_cmp_i;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count_q <= '0;
            cmp_q   <= '1; // compare resets to all ones
        end else begin
            if (load_i) begin
                count_q <= wr_data_i; // load beats a tick
            end else if (tick_i) begin
                if (wrap) begin
                    count_q <= '0;
                end else begin
                    count_q <= count_q + CNT_W'(1); // free run rolls over
                end
            end
            if (cmp_wr_i) begin
                cmp_q <= wr_data_i;
            end
        end
    end

    assign count_o = count_q;
    assign cmp_o   = cmp_q;

endmodule

//--- source/timer_mode_fsm.sv
`timescale 1ns/1ps

module timer_mode_fsm (
    input  logic clk,
    input  logic reset,
    input  logic en_i,       // TCSR enable
    input  logic one_shot_i, // TCSR one-shot
    input  logic match_i,    // counter hit compare
    output logic run_o,      // lets the prescaler count
    output logic expire_o    // clears enable in the slave
);
    import timer_pkg::*;

    timer_state_e state_q;
    timer_state_e state_d;
    logic         expire_set; // RUN to EXPIRED this cycle
    logic         expire_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            TIMER_IDLE: begin
                if (en_i) begin
                    state_d = TIMER_RUN;
                end
            end
            TIMER_RUN: begin
                if (!en_i) begin
                    state_d = TIMER_IDLE; // software stop
                end else if (match_i && one_shot_i) begin
                    state_d = TIMER_EXPIRED; // first match ends the run
                end
            end
            TIMER_EXPIRED: begin
                if (!en_i) begin
                    state_d = TIMER_IDLE; // enable gone, rearm possible
                end
            end
            default: begin
                state_d = TIMER_IDLE;
            end
        endcase
    end

    assign expire_set = (state_q == TIMER_RUN) && (state_d == TIMER_EXPIRED);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q  <= TIMER_IDLE;
            expire_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            expire_q <= expire_set; // pulse one clock after the match
        end
    end

    assign run_o    = (state_q == TIMER_RUN); // EXPIRED stops ticks
    assign expire_o = expire_q;

endmodule

//--- source/timer_pkg.sv
package timer_pkg;

    // word addresses on the slave port, decoded from addr_i
    typedef enum logic [2:0] {
        TCSR_ADDR = 3'd0, // control and status
        TLR_ADDR  = 3'd1, // load on write, live count on read
        TCMP_ADDR = 3'd2  // compare value
    } timer_reg_e;

    // mode FSM states
    typedef enum logic [1:0] {
        TIMER_IDLE    = 2'd0, // enable low, prescaler stopped
        TIMER_RUN     = 2'd1, // counting ticks
        TIMER_EXPIRED = 2'd2  // one-shot done, waiting for enable to clear
    } timer_state_e;

    // clock divide select, tick every 2^div_sel clocks
    localparam int DIV_SEL_W = 3;

    // TCSR field positions
    localparam int TCSR_EN_BIT       = 0; // timer enable
    localparam int TCSR_INT_EN_BIT   = 1; // irq enable
    localparam int TCSR_RST_CMP_BIT  = 2; // wrap to zero on match
    localparam int TCSR_ONE_SHOT_BIT = 3; // stop after first match
    localparam int TCSR_DIV_LSB      = 4; // div_sel in bits 6..4
    localparam int TCSR_ISR_BIT      = 7; // sticky flag, write 1 clears
    localparam int TCSR_W            = 8; // full register width

endpackage

//--- source/timer_top.sv
`timescale 1ns/1ps

module timer_top #(
    parameter int DATA_W = 32, // bus data width
    parameter int CNT_W  = 32, // timer width, at most DATA_W
    parameter int ADDR_W = 3   // bus address width
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              stb_i,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [DATA_W-1:0] dat_i,
    output logic [DATA_W-1:0] dat_o,
    output logic              ack_o,
    output logic              irq_o   // sticky compare interrupt
);
    import timer_pkg::*;

    logic                 en;         // TCSR enable
    logic                 one_shot;
    logic                 rst_on_cmp;
    logic [DIV_SEL_W-1:0] div_sel;
    logic                 load;       // TLR write strobe
    logic                 cmp_wr;     // TCMP write strobe
    logic [CNT_W-1:0]     wr_data;
    logic [CNT_W-1:0]     count;
    logic [CNT_W-1:0]     cmp;
    logic                 match;
    logic                 tick;
    logic                 run;
    logic                 expire;

    timer_bus_slave #(
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W),
        .CNT_W  (CNT_W)
    ) bus_slave_inst (
        .clk          (clk),
        .reset        (reset),
        .stb_i        (stb_i),
        .we_i         (we_i),
        .addr_i       (addr_i),
        .dat_i        (dat_i),
        .count_i      (count),
        .cmp_i        (cmp),
        .match_i      (match),
        .expire_i     (expire),
        .dat_o        (dat_o),
        .ack_o        (ack_o),
        .irq_o        (irq_o),
        .en_o         (en),
        .one_shot_o   (one_shot),
        .rst_on_cmp_o (rst_on_cmp),
        .div_sel_o    (div_sel),
        .load_o       (load),
        .cmp_wr_o     (cmp_wr),
        .wr_data_o    (wr_data)
    );

    clock_prescaler prescaler_inst (
        .clk       (clk),
        .reset     (reset),
        .run_i     (run),
        .div_sel_i (div_sel),
        .tick_o    (tick)
    );

    timer_counter #(
        .CNT_W (CNT_W)
    ) counter_inst (
        .clk          (clk),
        .reset        (reset),
        .tick_i       (tick),
        .rst_on_cmp_i (rst_on_cmp),
        .load_i       (load),
        .cmp_wr_i     (cmp_wr),
        .wr_data_i    (wr_data),
        .count_o      (count),
        .cmp_o        (cmp),
        .match_o      (match)
    );

    timer_mode_fsm mode_fsm_inst (
        .clk        (clk),
        .reset      (reset),
        .en_i       (en),
        .one_shot_i (one_shot),
        .match_i    (match),
        .run_o      (run),
        .expire_o   (expire)
    );

endmodule

//--- src.f
source/timer_pkg.sv
source/timer_bus_slave.sv
source/clock_prescaler.sv
source/timer_counter.sv
source/timer_mode_fsm.sv
source/timer_top.sv
verification/timer_clock_gen.sv
verification/timer_checker.sv
verification/timer_assertions.sv
verification/timer_tb.sv

//--- verification/timer_assertions.sv
`timescale 1ns/1ps

module timer_assertions (
    input logic                    clk_i,
    input logic                    reset_i,
    input logic                    ack_i,
    input logic                    irq_i,
    input logic                    int_en_i, // TCSR interrupt enable
    input logic                    run_i,    // prescaler run from the FSM
    input timer_pkg::timer_state_e state_i
);
    import timer_pkg::*;

    ack_one_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
        ack_i |=> !ack_i)
        else $error("ack_o high for two cycles");

    irq_masked: assert property (@(posedge clk_i) disable iff (reset_i)
        !(irq_i && !int_en_i))
        else $error("irq_o high with interrupt enable clear");

    expired_stopped: assert property (@(posedge clk_i) disable iff (reset_i)
        !(state_i == TIMER_EXPIRED && run_i))
        else $error("prescaler running in TIMER_EXPIRED");

endmodule

bind timer_top timer_assertions assertions_inst (
    .clk_i    (clk),
    .reset_i  (reset),
    .ack_i    (ack_o),
    .irq_i    (irq_o),
    .int_en_i (bus_slave_inst.tcsr_q[timer_pkg::TCSR_INT_EN_BIT]),
    .run_i    (run),
    .state_i  (mode_fsm_inst.state_q)
);

//--- verification/timer_checker.sv
`timescale 1ns/1ps

module timer_checker (
    input logic        clk_i,
    input logic        ack_i,
    input logic        we_i,
    input logic        irq_i,
    input logic [31:0] dat_i,
    input logic        exp_valid_i, // a read with a known result is in flight
    input logic [31:0] exp_data_i,
    input logic [2:0]  exp_addr_i
);
    import timer_pkg::*;

    int checks = 0;     // compares in the current test
    int errors = 0;     // failures in the current test
    int pass_tests = 0;
    int fail_tests = 0;

    function automatic string reg_name(input logic [2:0] a);
        case (a)
            TCSR_ADDR: return "TCSR";
            TLR_ADDR:  return "TLR";
            TCMP_ADDR: return "TCMP";
            default:   return "unmapped";
        endcase
    endfunction

    // dat_o is settled mid-cycle while ack_o is high
    always @(negedge clk_i) begin
        if (ack_i && !we_i && exp_valid_i) begin
            checks++;
            if (dat_i !== exp_data_i) begin
                $display("Fail at %0d ns: dat_o (%s read) expected %h, actual %h",
                         $time, reg_name(exp_addr_i), exp_data_i, dat_i);
                errors++;
            end
        end
    end

    task automatic check_irq(input logic exp);
        checks++;
        if (irq_i !== exp) begin
            $display("Fail at %0d ns: irq_o expected %b, actual %b", $time, exp, irq_i);
            errors++;
        end
    endtask

    task automatic check_number(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            $display("Fail at %0d ns: %s expected %0d, actual %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("At %0d ns: %s", $time, msg);
        errors++;
    endtask

    task automatic finish_test(input string name);
        if (errors == 0) begin
            pass_tests++;
        end else begin
            fail_tests++;
        end
        $display("test %s: %s (%0d checks, %0d errors)", name,
                 (errors == 0) ? "ok" : "failed", checks, errors);
        checks = 0;
        errors = 0;
    endtask

    task automatic print_totals();
        $display("tests passed: %0d, tests failed: %0d", pass_tests, fail_tests);
    endtask

endmodule

//--- verification/timer_clock_gen.sv
`timescale 1ns/1ps

module timer_clock_gen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #2 clk_o = ~clk_o; // 4 ns period

endmodule

//--- verification/timer_tb.sv
`timescale 1ns/1ps

module timer_tb;
    import timer_pkg::*;

    // rough test lengths in clocks, reset through free-run
    localparam int TIMEOUT_CYCLES = 4 * (16 + 40 + 250 + 1500 + 300 + 700 + 300);

    logic        clk;
    logic        reset;
    logic        stb;
    logic        we;
    logic [2:0]  addr;
    logic [31:0] dat_in;
    logic [31:0] dat_out;
    logic        ack;
    logic        irq;
    logic        exp_valid;
    logic [31:0] exp_data;
    logic [2:0]  exp_addr;
    logic [7:0]  sh_tcsr;  // shadow registers for expected reads
    logic [31:0] sh_load;
    logic [31:0] sh_cmp;
    int          cyc = 0;  // rising edges since time zero
    int          seed;

    timer_clock_gen clock_gen_inst (.clk_o(clk));

    timer_top #(
        .DATA_W (32),
        .CNT_W  (32),
        .ADDR_W (3)
    ) timer_top_inst (
        .clk    (clk),
        .reset  (reset),
        .stb_i  (stb),
        .we_i   (we),
        .addr_i (addr),
        .dat_i  (dat_in),
        .dat_o  (dat_out),
        .ack_o  (ack),
        .irq_o  (irq)
    );

    timer_checker checker_inst (
        .clk_i       (clk),
        .ack_i       (ack),
        .we_i        (we),
        .irq_i       (irq),
        .dat_i       (dat_out),
        .exp_valid_i (exp_valid),
        .exp_data_i  (exp_data),
        .exp_addr_i  (exp_addr)
    );

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cyc);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] ctrl_word(input logic en, input logic int_en,
                                              input logic rst, input logic one, input int div);
        logic [31:0] w;
        w = '0;
        w[TCSR_EN_BIT]       = en;
        w[TCSR_INT_EN_BIT]   = int_en;
        w[TCSR_RST_CMP_BIT]  = rst;
        w[TCSR_ONE_SHOT_BIT] = one;
        w[TCSR_DIV_LSB +: DIV_SEL_W] = 3'(div);
        return w;
    endfunction

    // expected register reads from the shadow copies
    function automatic logic [31:0] expect_read(input logic [2:0] a);
        case (a)
            TCSR_ADDR: return {24'd0, sh_tcsr};
            TLR_ADDR:  return sh_load;
            TCMP_ADDR: return sh_cmp;
            default:   return 32'd0;
        endcase
    endfunction

    function automatic int irq_delay(input logic [31:0] ld, input logic [31:0] cv, input int d);
        return int'(cv - ld + 32'd1) * (1 << d) + 1; // clocks from enable ack to irq
    endfunction

    function automatic int irq_period(input logic [31:0] cv, input int d);
        return (int'(cv) + 1) * (1 << d);
    endfunction

    function automatic logic [31:0] free_run_count(input logic [31:0] ld, input int d,
                                                   input int en_ack, input int rd_ack);
        int ticks;
        ticks = (rd_ack - en_ack - 2) >> d; // ticks landed before the read edge
        return ld + 32'(ticks);
    endfunction

    task automatic bus_access(input logic write, input logic [2:0] a, input logic [31:0] d,
                              input logic [31:0] exp, output int ack_cyc);
        int start;
        int waited;
        @(posedge clk);
        #1;
        stb = 1'b1;
        we = write;
        addr = a;
        dat_in = d;
        exp_valid = !write;
        exp_addr = a;
        exp_data = exp;
        start = cyc;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!ack && waited < 8);
        stb = 1'b0;
        ack_cyc = cyc;
        if (!ack) begin
            checker_inst.report_problem($sformatf("no ack for access to address %0d", a));
        end else if (cyc - start != 1) begin
            checker_inst.report_problem($sformatf("ack for address %0d came late", a));
        end
        @(negedge clk);
        #1; // checker has compared dat_o by now
    endtask

    task automatic reg_write(input logic [2:0] a, input logic [31:0] d);
        int unused_ack;
        bus_access(1'b1, a, d, 32'd0, unused_ack);
    endtask

    task automatic reg_write_at(input logic [2:0] a, input logic [31:0] d, output int ack_cyc);
        bus_access(1'b1, a, d, 32'd0, ack_cyc);
    endtask

    task automatic reg_read(input logic [2:0] a, input logic [31:0] exp);
        int unused_ack;
        bus_access(1'b0, a, 32'd0, exp, unused_ack);
    endtask

    task automatic wait_irq(input int limit, output int rise, output logic seen);
        int n;
        n = 0;
        seen = 1'b0;
        rise = 0;
        while (!seen && n < limit) begin
            @(posedge clk);
            #1;
            n++;
            if (irq) begin
                seen = 1'b1;
                rise = cyc;
            end
        end
    endtask

    // stop, load, compare, then enable; returns the enable ack cycle
    task automatic start_timer(input logic [31:0] ld, input logic [31:0] cv,
                               input logic [31:0] ctrl, output int en_ack);
        reg_write(TCSR_ADDR, 32'd0);
        reg_write(TLR_ADDR, ld);
        reg_write(TCMP_ADDR, cv);
        reg_write_at(TCSR_ADDR, ctrl, en_ack);
        sh_tcsr = ctrl[7:0];
    endtask

    task automatic test_reset();
        checker_inst.check_irq(1'b0);
        reg_read(TCSR_ADDR, 32'd0);
        reg_read(TLR_ADDR, 32'd0);
        reg_read(TCMP_ADDR, 32'hFFFF_FFFF);
        checker_inst.finish_test("reset values");
    endtask

    task automatic test_readback();
        for (int i = 0; i < 4; i++) begin
            sh_load = 32'($random(seed));
            sh_cmp = 32'($random(seed));
            sh_tcsr = 8'($random(seed)) & 8'h7E; // enable stays off
            reg_write(TLR_ADDR, sh_load);
            reg_write(TCMP_ADDR, sh_cmp);
            reg_write(TCSR_ADDR, {24'd0, sh_tcsr} | 32'h80); // w1c bit reads as flag
            reg_read(TLR_ADDR, expect_read(TLR_ADDR));
            reg_read(TCMP_ADDR, expect_read(TCMP_ADDR));
            reg_read(TCSR_ADDR, expect_read(TCSR_ADDR));
        end
        for (int a = 3; a < 8; a++) begin
            reg_write(3'(a), 32'($random(seed)));
            reg_read(3'(a), expect_read(3'(a)));
        end
        reg_read(TCSR_ADDR, expect_read(TCSR_ADDR)); // unmapped writes left these alone
        reg_read(TLR_ADDR, expect_read(TLR_ADDR));
        reg_read(TCMP_ADDR, expect_read(TCMP_ADDR));
        reg_write(TCSR_ADDR, 32'd0);
        sh_tcsr = 8'd0;
        checker_inst.finish_test("register readback");
    endtask

    task automatic test_periodic();
        logic [31:0] ld;
        logic [31:0] cv;
        int          en_ack;
        int          rise;
        logic        seen;
        for (int d = 0; d < 4; d++) begin
            ld = 32'($random(seed)) & 32'hF;
            cv = ld + 32'd4 + (32'($random(seed)) & 32'hF);
            start_timer(ld, cv, ctrl_word(1'b1, 1'b1, 1'b1, 1'b0, d), en_ack);
            wait_irq(irq_delay(ld, cv, d) + 16, rise, seen);
            if (!seen) begin
                checker_inst.report_problem($sformatf("irq_o never rose with div_sel %0d", d));
            end else begin
                checker_inst.check_number("irq_o rise delay", irq_delay(ld, cv, d), rise - en_ack);
            end
        end
        checker_inst.finish_test("periodic interrupt timing");
    endtask

    task automatic test_irq_clear();
        logic [31:0] ctrl;
        logic [31:0] cv;
        int          en_ack;
        int          rise1;
        int          rise2;
        logic        seen;
        cv = 32'd16 + (32'($random(seed)) & 32'h7);
        ctrl = ctrl_word(1'b1, 1'b1, 1'b1, 1'b0, 1);
        start_timer(32'd0, cv, ctrl, en_ack);
        wait_irq(irq_delay(32'd0, cv, 1) + 16, rise1, seen);
        if (!seen) begin
            checker_inst.report_problem("irq_o never rose before the clear");
        end
        reg_write(TCSR_ADDR, ctrl | 32'h80);
        checker_inst.check_irq(1'b0);
        wait_irq(irq_period(cv, 1) + 16, rise2, seen);
        if (!seen) begin
            checker_inst.report_problem("irq_o did not return after the clear");
        end else begin
            checker_inst.check_number("irq_o repeat period", irq_period(cv, 1), rise2 - rise1);
        end
        ctrl[TCSR_INT_EN_BIT] = 1'b0;
        reg_write(TCSR_ADDR, ctrl);
        sh_tcsr = ctrl[7:0];
        checker_inst.check_irq(1'b0);
        reg_read(TCSR_ADDR, expect_read(TCSR_ADDR));
        checker_inst.finish_test("interrupt clear and masking");
    endtask

    task automatic test_one_shot();
        logic [31:0] ctrl;
        logic [31:0] ld;
        logic [31:0] cv;
        int          en_ack;
        int          rise;
        logic        seen;
        ld = 32'($random(seed)) & 32'h7;
        cv = ld + 32'd6;
        ctrl = ctrl_word(1'b1, 1'b1, 1'b1, 1'b1, 1);
        start_timer(ld, cv, ctrl, en_ack);
        wait_irq(irq_delay(ld, cv, 1) + 16, rise, seen);
        if (!seen) begin
            checker_inst.report_problem("one-shot run gave no interrupt");
        end else begin
            checker_inst.check_number("irq_o rise delay", irq_delay(ld, cv, 1), rise - en_ack);
        end
        repeat (4) @(posedge clk);
        sh_tcsr = (ctrl[7:0] & 8'hFE) | 8'h80; // enable cleared, flag set
        reg_read(TCSR_ADDR, expect_read(TCSR_ADDR));
        reg_read(TLR_ADDR, 32'd0);
        repeat (200) @(posedge clk);
        reg_read(TLR_ADDR, 32'd0);
        reg_write(TCSR_ADDR, (ctrl & 32'hFFFF_FFFE) | 32'h80);
        checker_inst.check_irq(1'b0);
        wait_irq(200, rise, seen);
        if (seen) begin
            checker_inst.report_problem("irq_o rose again after the one-shot run ended");
        end
        checker_inst.finish_test("one-shot mode");
    endtask

    task automatic test_free_run();
        logic [31:0] ld;
        int          en_ack;
        int          rd_ack;
        ld = 32'($random(seed)) & 32'hFF;
        start_timer(ld, ld + 32'd3, ctrl_word(1'b1, 1'b0, 1'b0, 1'b0, 2), en_ack);
        for (int i = 0; i < 2; i++) begin
            repeat (60 + 7 * i) @(posedge clk);
            #1;
            rd_ack = cyc + 2; // drive next cycle, ack one after
            reg_read(TLR_ADDR, free_run_count(ld, 2, en_ack, rd_ack));
        end
        reg_write(TCSR_ADDR, 32'd0);
        checker_inst.finish_test("free-run past compare");
    endtask

    initial begin
        stb = 1'b0;
        we = 1'b0;
        addr = 3'd0;
        dat_in = 32'd0;
        exp_valid = 1'b0;
        exp_data = 32'd0;
        exp_addr = 3'd0;
        sh_tcsr = 8'd0;
        sh_load = 32'd0;
        sh_cmp = 32'hFFFF_FFFF;
        seed = 32'h91b1_1f44;
        reset = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset();
        test_readback();
        test_periodic();
        test_irq_clear();
        test_one_shot();
        test_free_run();
        checker_inst.print_totals();
        if (checker_inst.fail_tests == 0 && checker_inst.pass_tests == 6) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
